// ==== source/spinnaker_link_macros.svh ====
// spinnaker link transmitter constants
// widths and flit counts fixed by the link protocol

`ifndef SPINNAKER_LINK_MACROS_SVH
`define SPINNAKER_LINK_MACROS_SVH

// ----------------------------------------------------------------------
// packet port
// ----------------------------------------------------------------------
`define PKT_BITS      72  // long packet, short ones use the low 40
`define NIBBLE_BITS   4   // one data flit carries a nibble

// nibbles per packet, eop flit not counted
`define SHORT_NIBBLES 10
`define LONG_NIBBLES  18

`define FLIT_CNT_BITS 5   // enough for LONG_NIBBLES

// ----------------------------------------------------------------------
// link side
// ----------------------------------------------------------------------
`define SYM_BITS      7   // 2-of-7 wires
`define SYNC_STAGES   2   // ack synchronizer flops

`endif

// ==== source/spinnaker_link_pkg.sv ====
// spinnaker link transmitter types
// packet, flit and symbol vectors plus the fsm encodings

`default_nettype none

`include "spinnaker_link_macros.svh"

package spinnaker_link_pkg;

  // ----------------------------------------------------------------------
  // vectors
  // ----------------------------------------------------------------------
  typedef logic [`PKT_BITS-1:0]      pkt_t;       // short or long packet
  typedef logic [`NIBBLE_BITS-1:0]   nibble_t;    // one data flit payload
  typedef logic [`SYM_BITS-1:0]      sym_t;       // wire levels or a code
  typedef logic [`FLIT_CNT_BITS-1:0] flit_cnt_t;  // nibbles already sent

  // serializer to output stage
  typedef struct packed {
    logic    eop;  // end-of-packet, nib ignored
    nibble_t nib;  // data nibble
  } flit_t;

  // ----------------------------------------------------------------------
  // state machines
  // ----------------------------------------------------------------------
  typedef enum logic {
    SER_IDLE,  // waiting for a packet
    SER_SEND   // offering flits
  } ser_state_e;

  typedef enum logic {
    TX_READY,    // may put a flit on the wires
    TX_WAIT_ACK  // symbol out, waiting for ack toggle
  } tx_state_e;

endpackage

`default_nettype wire

// ==== source/nrz_2of7_encoder.sv ====
// nrz 2-of-7 encoder
// looks up the code of a flit and toggles those two wires

`timescale 1ns/1ns
`default_nettype none

module nrz_2of7_encoder
  import spinnaker_link_pkg::*;
(
  input  wire flit_t flit,
  input  wire sym_t  cur_sym,   // levels now on the wires
  output sym_t       next_sym   // levels after this flit
);

  localparam sym_t EOP_CODE = 7'b1100000;

  sym_t code;  // the two wires to toggle

  always_comb begin
    if (flit.eop) begin
      code = EOP_CODE;  // nibble don't care
    end else begin
      case (flit.nib)
        4'h0: code = 7'b0010001;
        4'h1: code = 7'b0010010;
        4'h2: code = 7'b0010100;
        4'h3: code = 7'b0011000;
        4'h4: code = 7'b0100001;
        4'h5: code = 7'b0100010;
        4'h6: code = 7'b0100100;
        4'h7: code = 7'b0101000;
        4'h8: code = 7'b1000001;
        4'h9: code = 7'b1000010;
        4'ha: code = 7'b1000100;
        4'hb: code = 7'b1001000;
        4'hc: code = 7'b0000011;  // low wires only from here on
        4'hd: code = 7'b0000110;
        4'he: code = 7'b0001100;
        4'hf: code = 7'b0001001;
        default: code = EOP_CODE;
      endcase
    end
  end

  // nrz, a flit is a change of level not a level
  assign next_sym = cur_sym ^ code;

endmodule

`default_nettype wire

// ==== source/pkt_serializer.sv ====
// packet serializer
// buffers one packet and hands it out nibble by nibble, lsb first,
// followed by an end-of-packet flit

`timescale 1ns/1ns
`default_nettype none

`include "spinnaker_link_macros.svh"

module pkt_serializer
  import spinnaker_link_pkg::*;
(
  input  wire       CLK_IN,
  input  wire       RESET_IN,
  // packet port
  input  wire pkt_t pkt_data,
  input  wire       pkt_vld,
  output logic      pkt_rdy,
  // flit port to the output stage
  output flit_t     flit,
  output logic      flt_vld,
  input  wire       flt_rdy
);

  // ----------------------------------------------------------------------
  // internal signals
  // ----------------------------------------------------------------------
  ser_state_e state;

  pkt_t       pkt_buf;   // remaining nibbles, current one at the bottom
  logic       long_pkt;  // length bit of the stored packet
  flit_cnt_t  flit_cnt;  // data nibbles already transferred

  logic       accept;    // packet taken this cycle
  logic       flt_xfer;  // flit taken by the output stage
  logic       eop_due;   // all nibbles gone, offer eop
  nibble_t    cur_nib;

  assign accept   = pkt_vld && pkt_rdy;
  assign flt_xfer = flt_vld && flt_rdy;

  // ----------------------------------------------------------------------
  // end-of-packet decision
  // ----------------------------------------------------------------------
  always_comb begin
    if (long_pkt) begin
      eop_due = (flit_cnt == flit_cnt_t'(`LONG_NIBBLES));
    end else begin
      eop_due = (flit_cnt == flit_cnt_t'(`SHORT_NIBBLES));
    end
  end

  // nibble forced to zero on eop, encoder ignores it anyway
  assign cur_nib  = eop_due ? '0 : pkt_buf[`NIBBLE_BITS-1:0];

  assign flit.eop = eop_due;
  assign flit.nib = cur_nib;

  // ----------------------------------------------------------------------
  // packet buffer
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK_IN) begin
    if (accept) begin
      pkt_buf  <= pkt_data;     // nibble 0 offered next cycle
      long_pkt <= pkt_data[1];  // bit 1 selects 72-bit format
    end else if (flt_xfer) begin
      pkt_buf  <= pkt_buf >> `NIBBLE_BITS;  // next nibble down
    end
  end

  // ----------------------------------------------------------------------
  // control fsm, handshakes and flit counter
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state    <= SER_IDLE;
      pkt_rdy  <= 1'b1;  // ready straight out of reset
      flt_vld  <= 1'b0;
      flit_cnt <= '0;
    end else begin
      case (state)
        SER_IDLE: begin
          if (accept) begin
            state    <= SER_SEND;
            pkt_rdy  <= 1'b0;  // one packet at a time
            flt_vld  <= 1'b1;  // nibble 0 valid next cycle
            flit_cnt <= '0;
          end
        end

        SER_SEND: begin
          // nothing moves while the output stage holds off
          if (flt_xfer) begin
            if (eop_due) begin
              state   <= SER_IDLE;  // eop gone, packet done
              pkt_rdy <= 1'b1;
              flt_vld <= 1'b0;
            end else begin
              flit_cnt <= flit_cnt + 1'b1;  // one more nibble sent
            end
          end
        end

        default: begin
          state <= SER_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/link_flit_tx.sv ====
// link flit output stage
// registers the symbol onto the wires and paces flits, one per
// toggle of the synchronized acknowledge

`timescale 1ns/1ns
`default_nettype none

`include "spinnaker_link_macros.svh"

module link_flit_tx
  import spinnaker_link_pkg::*;
(
  input  wire       CLK_IN,
  input  wire       RESET_IN,
  // flit port from the serializer
  input  wire       flt_vld,
  output logic      flt_rdy,
  input  wire sym_t next_sym,      // already encoded against the wires
  // link wires
  output sym_t      sl_data_2of7,
  input  wire       sl_ack         // async from the receiver
);

  // ----------------------------------------------------------------------
  // internal signals
  // ----------------------------------------------------------------------
  tx_state_e               state;
  logic [`SYNC_STAGES-1:0] ack_sync;    // synchronizer chain
  logic                    ack_synced;  // ack in the CLK_IN domain
  logic                    ack_seen;    // ack level when last flit went
  logic                    send_flit;

  assign ack_synced = ack_sync[`SYNC_STAGES-1];

  assign flt_rdy    = (state == TX_READY);
  assign send_flit  = flt_vld && flt_rdy;

  // ----------------------------------------------------------------------
  // ack synchronizer
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      ack_sync <= '0;
    end else begin
      ack_sync <= {ack_sync[`SYNC_STAGES-2:0], sl_ack};  // lsb first stage
    end
  end

  // ----------------------------------------------------------------------
  // wires, ack record and pacing fsm
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state        <= TX_READY;  // first flit may go at once
      sl_data_2of7 <= '0;        // link idles with all wires low
      ack_seen     <= 1'b0;
    end else begin
      case (state)
        TX_READY: begin
          if (send_flit) begin
            sl_data_2of7 <= next_sym;     // two wires toggle
            ack_seen     <= ack_synced;   // wait for this to change
            state        <= TX_WAIT_ACK;
          end
        end

        TX_WAIT_ACK: begin
          // any ack edge, rising or falling, frees the next flit
          if (ack_synced != ack_seen) begin
            state <= TX_READY;
          end
        end

        default: begin
          state <= TX_READY;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/spinnaker_link_sender.sv ====
// spinnaker link transmitter top
// packet in, nrz 2-of-7 symbols out, one flit per ack toggle

`timescale 1ns/1ns
`default_nettype none

module spinnaker_link_sender
  import spinnaker_link_pkg::*;
(
  input  wire       CLK_IN,
  input  wire       RESET_IN,
  // packet port
  input  wire pkt_t pkt_data,
  input  wire       pkt_vld,
  output logic      pkt_rdy,
  // link wires
  output sym_t      sl_data_2of7,
  input  wire       sl_ack        // async, toggles once per symbol
);

  flit_t flit;      // current flit from the serializer
  logic  flt_vld;
  logic  flt_rdy;
  sym_t  next_sym;  // wire levels once flit is applied

  pkt_serializer u_ser (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .flit     (flit),
    .flt_vld  (flt_vld),
    .flt_rdy  (flt_rdy)
  );

  // encoder works from the live wire levels
  nrz_2of7_encoder u_enc (
    .flit     (flit),
    .cur_sym  (sl_data_2of7),
    .next_sym (next_sym)
  );

  link_flit_tx u_tx (
    .CLK_IN       (CLK_IN),
    .RESET_IN     (RESET_IN),
    .flt_vld      (flt_vld),
    .flt_rdy      (flt_rdy),
    .next_sym     (next_sym),
    .sl_data_2of7 (sl_data_2of7),
    .sl_ack       (sl_ack)
  );

endmodule

`default_nettype wire

// ==== sim/spinnaker_link_properties.sv ====
// link output stage protocol checks
// bound into link_flit_tx, one symbol change per accepted flit

`timescale 1ns/1ns
`default_nettype none

module spinnaker_link_properties
  import spinnaker_link_pkg::*;
(
  input wire            CLK_IN,
  input wire            RESET_IN,
  input wire tx_state_e state,
  input wire            flt_vld,
  input wire            flt_rdy,
  input wire sym_t      next_sym,
  input wire sym_t      sl_data_2of7
);

  // ----------------------------------------------------------------------
  // wires move only when a flit is sent
  // ----------------------------------------------------------------------
  property p_change_on_send;
    @(posedge CLK_IN) disable iff (RESET_IN)
      (sl_data_2of7 != $past(sl_data_2of7)) |->
        ($past(state) == TX_READY && $past(flt_vld));
  endproperty

  // nrz 2-of-7, exactly two wires per flit
  property p_two_toggles;
    @(posedge CLK_IN) disable iff (RESET_IN)
      (sl_data_2of7 != $past(sl_data_2of7)) |->
        ($countones(sl_data_2of7 ^ $past(sl_data_2of7)) == 2);
  endproperty

  // flit offered during an ack wait stays put until taken
  property p_hold_while_waiting;
    @(posedge CLK_IN) disable iff (RESET_IN)
      (flt_vld && !flt_rdy) |=> (flt_vld && $stable(next_sym));
  endproperty

  a_change_on_send: assert property (p_change_on_send)
    else $error("link wires changed without a flit transfer");
  a_two_toggles: assert property (p_two_toggles)
    else $error("symbol change did not toggle exactly two wires");
  a_hold_while_waiting: assert property (p_hold_while_waiting)
    else $error("offered flit changed or dropped while the output stage held it off");

endmodule

bind link_flit_tx spinnaker_link_properties u_props (
  .CLK_IN       (CLK_IN),
  .RESET_IN     (RESET_IN),
  .state        (state),
  .flt_vld      (flt_vld),
  .flt_rdy      (flt_rdy),
  .next_sym     (next_sym),
  .sl_data_2of7 (sl_data_2of7)
);

`default_nettype wire

// ==== sim/spinnaker_link_sender_tb.sv ====
// spinnaker link transmitter testbench
// random packets in, receiver model decodes the 2-of-7 wires and acks

`timescale 1ns/1ns
`default_nettype none

`include "spinnaker_link_macros.svh"

module spinnaker_link_sender_tb;
  import spinnaker_link_pkg::*;

  localparam int NUM_PKTS       = 200;
  // worst case about 14 cycles per flit, 19 flits per long packet
  localparam int TIMEOUT_CYCLES = NUM_PKTS * (`LONG_NIBBLES + 1) * 14 + 6800;

  logic CLK_IN;
  logic RESET_IN;
  pkt_t pkt_data;
  logic pkt_vld;
  logic pkt_rdy;
  sym_t sl_data_2of7;
  logic sl_ack;

  pkt_t sent_q[$];             // accepted, not yet received
  pkt_t stim_pkt;
  pkt_t rx_buf;                // packet being rebuilt
  pkt_t exp_pkt;
  sym_t prev_sym;
  int   rx_cnt, rx_pkts, exp_nibs, ack_wait, gap, cycle_cnt;
  logic ack_pending;           // symbol seen, ack not yet toggled
  int   err_reset, err_code, err_short, err_long, err_flow;
  int   chk_reset, chk_code, chk_short, chk_long, chk_flow, held_acks;

  spinnaker_link_sender UUT (
    .CLK_IN       (CLK_IN),
    .RESET_IN     (RESET_IN),
    .pkt_data     (pkt_data),
    .pkt_vld      (pkt_vld),
    .pkt_rdy      (pkt_rdy),
    .sl_data_2of7 (sl_data_2of7),
    .sl_ack       (sl_ack)
  );

  always #4 CLK_IN = ~CLK_IN;  // 8 ns period

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  // receiver copy of the 2-of-7 table, 16 is eop, -1 no entry
  function automatic int code_to_flit(input sym_t diff);
    case (diff)
      7'b0010001: return 0;
      7'b0010010: return 1;
      7'b0010100: return 2;
      7'b0011000: return 3;
      7'b0100001: return 4;
      7'b0100010: return 5;
      7'b0100100: return 6;
      7'b0101000: return 7;
      7'b1000001: return 8;
      7'b1000010: return 9;
      7'b1000100: return 10;
      7'b1001000: return 11;
      7'b0000011: return 12;
      7'b0000110: return 13;
      7'b0001100: return 14;
      7'b0001001: return 15;
      7'b1100000: return 16;
      default:    return -1;
    endcase
  endfunction

  function automatic pkt_t make_packet();
    pkt_t p;
    logic is_long;
    is_long   = 1'($urandom_range(1, 0));
    p[31:0]   = $urandom;
    p[63:32]  = $urandom;
    p[71:64]  = 8'($urandom);
    p[1]      = is_long;  // length bit
    if (!is_long) begin
      p[71:40] = '0;      // short packet is 40 bits
    end
    return p;
  endfunction

  task automatic report_test(input string name, input int errs, input int checks);
    if (errs == 0) begin
      $display("PASS %s (%0d checks)", name, checks);
    end else begin
      $display("FAIL %s (%0d of %0d checks wrong)", name, errs, checks);
    end
  endtask

  // ----------------------------------------------------------------------
  // receiver model, sampled mid-cycle where the wires are stable
  // ----------------------------------------------------------------------
  always @(negedge CLK_IN) begin
    int dec;
    if (!RESET_IN && sl_data_2of7 != prev_sym) begin
      dec = code_to_flit(sl_data_2of7 ^ prev_sym);
      chk_code++;
      chk_flow++;
      assert ($countones(sl_data_2of7 ^ prev_sym) == 2 && dec >= 0) else begin
        $display("** Error two_of_seven: expected 2 toggled wires in a table entry, actual %b",
                 sl_data_2of7 ^ prev_sym);
        err_code++;
      end
      assert (!ack_pending) else begin
        $display("wires changed again before the previous symbol was acknowledged");
        err_flow++;
      end
      if (dec == 16) begin                        // eop, compare packet
        assert (sent_q.size() > 0) else begin
          $display("end-of-packet arrived with no packet outstanding");
          err_flow++;
        end
        if (sent_q.size() > 0) begin
          exp_pkt  = sent_q.pop_front();
          exp_nibs = exp_pkt[1] ? `LONG_NIBBLES : `SHORT_NIBBLES;
          if (exp_pkt[1]) begin
            chk_long++;
            assert (rx_buf == exp_pkt && rx_cnt == exp_nibs) else begin
              $display("** Error long_packets: expected %h (%0d nibbles), actual %h (%0d)",
                       exp_pkt, exp_nibs, rx_buf, rx_cnt);
              err_long++;
            end
          end else begin
            chk_short++;
            assert (rx_buf == exp_pkt && rx_cnt == exp_nibs) else begin
              $display("** Error short_packets: expected %h (%0d nibbles), actual %h (%0d)",
                       exp_pkt, exp_nibs, rx_buf, rx_cnt);
              err_short++;
            end
          end
        end
        rx_pkts++;
        rx_buf = '0;
        rx_cnt = 0;
      end else if (dec >= 0) begin
        rx_buf = rx_buf | (pkt_t'(dec) << (`NIBBLE_BITS * rx_cnt));  // lsb nibble first
        rx_cnt++;
      end
      prev_sym    = sl_data_2of7;
      ack_pending = 1'b1;
      if ($urandom_range(19, 0) == 0) begin
        ack_wait = 40;  // slow receiver
        held_acks++;
      end else begin
        ack_wait = $urandom_range(8, 1);
      end
    end else if (!RESET_IN && ack_pending) begin
      ack_wait--;
      if (ack_wait == 0) begin
        sl_ack      = ~sl_ack;  // nrz ack, any edge counts
        ack_pending = 1'b0;
      end
    end
  end

  // cycle limit
  always @(posedge CLK_IN) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: only %0d of %0d packets received after %0d cycles",
               rx_pkts, NUM_PKTS, cycle_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    void'($urandom(99));
    CLK_IN      = 1'b0;
    RESET_IN    = 1'b1;
    pkt_data    = '0;
    pkt_vld     = 1'b0;
    sl_ack      = 1'b0;
    prev_sym    = '0;
    rx_buf      = '0;
    ack_pending = 1'b0;
    repeat (9) begin  // 8 reset cycles plus the first one after
      @(negedge CLK_IN);
      chk_reset++;
      assert (pkt_rdy == 1'b1 && sl_data_2of7 == '0) else begin
        $display("** Error reset_state: expected rdy 1 wires 0000000, actual rdy %b wires %b",
                 pkt_rdy, sl_data_2of7);
        err_reset++;
      end
      RESET_IN = (chk_reset < 8);
    end
    report_test("reset_state", err_reset, chk_reset);

    for (int i = 0; i < NUM_PKTS; i++) begin
      gap = $urandom_range(3, 0);
      repeat (gap) @(negedge CLK_IN);
      stim_pkt = make_packet();
      pkt_data = stim_pkt;
      pkt_vld  = 1'b1;
      while (!pkt_rdy) @(negedge CLK_IN);
      sent_q.push_back(stim_pkt);  // taken on the coming rising edge
      @(negedge CLK_IN);
      pkt_vld  = 1'b0;
    end

    while (rx_pkts < NUM_PKTS) @(negedge CLK_IN);
    repeat (40) @(negedge CLK_IN);  // catch stray symbols
    chk_flow++;
    assert (sent_q.size() == 0 && rx_pkts == NUM_PKTS) else begin
      $display("** Error flow_control: expected 0 packets left, actual %0d left, %0d received",
               sent_q.size(), rx_pkts);
      err_flow++;
    end

    report_test("two_of_seven", err_code, chk_code);
    report_test("short_packets", err_short, chk_short);
    report_test("long_packets", err_long, chk_long);
    report_test("flow_control", err_flow, chk_flow);
    $display("tests 5, checks %0d, errors %0d, held acks %0d",
             chk_reset + chk_code + chk_short + chk_long + chk_flow,
             err_reset + err_code + err_short + err_long + err_flow, held_acks);
    if (err_reset + err_code + err_short + err_long + err_flow == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+source
source/spinnaker_link_pkg.sv
source/nrz_2of7_encoder.sv
source/pkt_serializer.sv
source/link_flit_tx.sv
source/spinnaker_link_sender.sv
sim/spinnaker_link_properties.sv
sim/spinnaker_link_sender_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log.

verilator --binary --timing --assert -f files.f \
  --top-module spinnaker_link_sender_tb -o sim_tb > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator exited with nonzero status"

grep -q "Finished with errors" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log \
  || { echo "RESULT: FAIL (run did not complete)"; exit 1; }
echo "RESULT: PASS"
